// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_id_top
RTL_TOP    ?= id_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_id_top.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module tb_id_top
    import id_pkg::*;
();

    localparam int TIMEOUT_CYC = 20;

    localparam logic [5:0] OPS [16] = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI,
        `OP_ORI, `OP_XORI, `OP_LUI, `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_SB,
        `OP_SH, `OP_SW};
    localparam aluop_t OP_ALU [16] = '{ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU, ALU_ANDI,
        ALU_ORI, ALU_XORI, ALU_LUI, ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_SB,
        ALU_SH, ALU_SW};
    localparam logic [5:0] FUNCS [16] = '{`FUNC_ADD, `FUNC_ADDU, `FUNC_SUB, `FUNC_SUBU,
        `FUNC_SLT, `FUNC_SLTU, `FUNC_AND, `FUNC_OR, `FUNC_NOR, `FUNC_XOR, `FUNC_SLL,
        `FUNC_SRL, `FUNC_SRA, `FUNC_SLLV, `FUNC_SRLV, `FUNC_SRAV};
    localparam aluop_t FUNC_ALU [16] = '{ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT,
        ALU_SLTU, ALU_AND, ALU_OR, ALU_NOR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV,
        ALU_SRLV, ALU_SRAV};

    logic               cpu_clk;
    logic               arst_n_i;
    logic [`WORD_W-1:0] inst_i;
    logic [`WORD_W-1:0] rd1_i;
    logic [`WORD_W-1:0] rd2_i;
    fwd_src_t           exe_fwd_i;
    fwd_src_t           mem_fwd_i;
    rf_rd_t             rf_rd_o;
    logic               stall_o;
    id_exe_t            id_exe_o;

    rf_rd_t  exp_rf;
    logic    exp_stall;
    id_exe_t exp_exe;   // content due after the next edge
    int      checks;
    int      errors;

    id_top DUT (
        .cpu_clk   (cpu_clk),
        .arst_n_i  (arst_n_i),
        .inst_i    (inst_i),
        .rd1_i     (rd1_i),
        .rd2_i     (rd2_i),
        .exe_fwd_i (exe_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .rf_rd_o   (rf_rd_o),
        .stall_o   (stall_o),
        .id_exe_o  (id_exe_o)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #2 cpu_clk = ~cpu_clk;
    end

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] rand_inst();
        logic [31:0] w;
        logic [3:0]  k;
        int          r;
        w = $urandom;
        k = 4'($urandom_range(15, 0));
        r = $urandom_range(9, 0);
        if (r == 0) begin
            return w;   // arbitrary word that mostly decodes as a no-op
        end
        if (r < 5) begin
            w[31:26] = `OP_SPECIAL;
            w[5:0]   = FUNCS[k];
            w[15:11] = 5'($urandom_range(3, 0));
        end else begin
            w[31:26] = OPS[k];
        end
        w[25:21] = 5'($urandom_range(3, 0));   // small range so forwarding hits
        w[20:16] = 5'($urandom_range(3, 0));
        return w;
    endfunction

    function automatic fwd_src_t rand_src(input int mode);
        fwd_src_t s;
        s.wreg = (mode > 0) ? 1'($urandom_range(1, 0)) : 1'b0;
        s.mreg = (mode > 1) ? ($urandom_range(3, 0) == 0) : 1'b0;
        s.wa   = 5'($urandom_range(3, 0));
        s.wd   = $urandom;
        return s;
    endfunction

    function automatic logic [31:0] pick(input logic en, input logic [4:0] ra,
                                         input logic [31:0] rf);
        if (!en) return '0;
        if (exe_fwd_i.wreg && exe_fwd_i.wa == ra) return exe_fwd_i.wd;
        if (mem_fwd_i.wreg && mem_fwd_i.wa == ra) return mem_fwd_i.wd;
        return rf;
    endfunction

    function automatic logic load_hazard(input fwd_src_t s);
        return s.wreg && s.mreg && ((exp_rf.rreg1 && s.wa == exp_rf.ra1) ||
                                    (exp_rf.rreg2 && s.wa == exp_rf.ra2));
    endfunction

    task automatic predict();
        logic [31:0] w;
        logic [5:0]  op;
        logic [5:0]  func;
        logic [31:0] imm_ext;
        aluop_t      aluop;
        logic        special;
        logic        valid;
        logic        load;
        logic        store;
        logic        immalu;
        logic        shamt;
        w       = swap_bytes(inst_i);   // swap is its own inverse
        op      = w[31:26];
        func    = w[5:0];
        special = (op == `OP_SPECIAL);
        aluop   = ALU_NOP;
        for (int i = 0; i < 16; i++) begin
            if (special && func == FUNCS[4'(i)]) aluop = FUNC_ALU[4'(i)];
            if (!special && op == OPS[4'(i)]) aluop = OP_ALU[4'(i)];
        end
        valid  = (aluop != ALU_NOP);
        load   = valid && op[5:3] == 3'b100;
        store  = valid && op[5:3] == 3'b101;
        immalu = valid && op[5:3] == 3'b001;
        shamt  = valid && special && func[5:2] == 4'b0000;   // sll, srl, sra
        exp_rf.rreg1 = valid && !shamt && aluop != ALU_LUI;
        exp_rf.ra1   = w[25:21];
        exp_rf.rreg2 = valid && !immalu && !load;
        exp_rf.ra2   = w[20:16];
        exp_stall    = load_hazard(exe_fwd_i) || load_hazard(mem_fwd_i);
        if (aluop == ALU_LUI) begin
            imm_ext = {w[15:0], 16'h0};
        end else if (load || store || (immalu && !op[2])) begin
            imm_ext = {{16{w[15]}}, w[15:0]};
        end else begin
            imm_ext = {16'h0, w[15:0]};
        end
        exp_exe = '0;
        if (!exp_stall) begin
            if (!valid) exp_exe.alutype = NOP;
            else if (special && func[5:3] == 3'b000) exp_exe.alutype = SHIFT;
            else if ((special && func[5:2] == 4'b1001) || (immalu && op[2]))
                exp_exe.alutype = LOGIC;
            else exp_exe.alutype = ARITH;
            exp_exe.aluop = aluop;
            exp_exe.wreg  = valid && !store;
            exp_exe.mreg  = load;
            exp_exe.wa    = (immalu || load) ? w[20:16] : w[15:11];
            exp_exe.src1  = shamt ? {27'h0, w[10:6]} : pick(exp_rf.rreg1, exp_rf.ra1, rd1_i);
            exp_exe.src2  = (immalu || load || store) ? imm_ext
                                                      : pick(exp_rf.rreg2, exp_rf.ra2, rd2_i);
            exp_exe.din   = pick(exp_rf.rreg2, exp_rf.ra2, rd2_i);
        end
    endtask

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        end
    endtask

    task automatic check_exe(input id_exe_t e);
        check("id_exe_o.alutype", 128'(e.alutype), 128'(id_exe_o.alutype));
        check("id_exe_o.aluop", 128'(e.aluop), 128'(id_exe_o.aluop));
        check("id_exe_o.wreg", 128'(e.wreg), 128'(id_exe_o.wreg));
        check("id_exe_o.mreg", 128'(e.mreg), 128'(id_exe_o.mreg));
        check("id_exe_o.wa", 128'(e.wa), 128'(id_exe_o.wa));
        check("id_exe_o.src1", 128'(e.src1), 128'(id_exe_o.src1));
        check("id_exe_o.src2", 128'(e.src2), 128'(id_exe_o.src2));
        check("id_exe_o.din", 128'(e.din), 128'(id_exe_o.din));
    endtask

    task automatic drive(input int mode);
        inst_i    = swap_bytes(rand_inst());
        rd1_i     = $urandom;
        rd2_i     = $urandom;
        exe_fwd_i = rand_src(mode);
        mem_fwd_i = rand_src(mode);
    endtask

    // mode 0 no pending writes, 1 forwarding, 2 forwarding plus loads
    task automatic run_phase(input string name, input int mode, input int n);
        int err0;
        err0 = errors;
        repeat (n) begin
            @(negedge cpu_clk);
            check_exe(exp_exe);
            drive(mode);
            #1;
            predict();
            check("rf_rd_o", 128'(exp_rf), 128'(rf_rd_o));
            check("stall_o", 128'(exp_stall), 128'(stall_o));
        end
        @(negedge cpu_clk);
        check_exe(exp_exe);   // registered result of the last instruction
        $display("test %s finished: %0d errors", name, errors - err0);
    endtask

    initial begin
        void'($urandom(47));
        checks    = 0;
        errors    = 0;
        arst_n_i  = 1'b0;
        inst_i    = '0;
        rd1_i     = '0;
        rd2_i     = '0;
        exe_fwd_i = '0;
        mem_fwd_i = '0;
        exp_rf    = '0;
        exp_stall = 1'b0;
        exp_exe   = '0;
        repeat (16) begin
            @(negedge cpu_clk);
            check_exe('0);
            drive(2);
        end
        arst_n_i = 1'b1;
        check_exe('0);
        inst_i    = swap_bytes({`OP_ADDI, 5'd1, 5'd2, 16'h8001});
        exe_fwd_i = rand_src(0);
        mem_fwd_i = rand_src(0);
        #1;
        predict();
        for (int cnt = 0; cnt < TIMEOUT_CYC && id_exe_o.aluop == ALU_NOP; cnt++) begin
            @(posedge cpu_clk);
            #1;
        end
        if (id_exe_o.aluop == ALU_NOP) begin
            $display("timeout: no registered result within %0d cycles of reset", TIMEOUT_CYC);
            errors++;
        end else begin
            check_exe(exp_exe);
            $display("test reset finished: %0d errors", errors);
            run_phase("decode", 0, 400);
            run_phase("forwarding", 1, 400);
            run_phase("load-use stall", 2, 400);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: include/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath widths
`define WORD_W      32
`define REG_ADDR_W  5
`define IMM_W       16
`define SA_W        5
`define OP_W        6
`define FUNC_W      6
`define ALUTYPE_W   3
`define ALUOP_W     8

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

// function field codes of SPECIAL
`define FUNC_SLL    6'b000000
`define FUNC_SRL    6'b000010
`define FUNC_SRA    6'b000011
`define FUNC_SLLV   6'b000100
`define FUNC_SRLV   6'b000110
`define FUNC_SRAV   6'b000111
`define FUNC_ADD    6'b100000
`define FUNC_ADDU   6'b100001
`define FUNC_SUB    6'b100010
`define FUNC_SUBU   6'b100011
`define FUNC_AND    6'b100100
`define FUNC_OR     6'b100101
`define FUNC_XOR    6'b100110
`define FUNC_NOR    6'b100111
`define FUNC_SLT    6'b101010
`define FUNC_SLTU   6'b101011

`endif

// File: src.f
+incdir+include
src/id_pkg.sv
src/inst_decoder.sv
src/operand_fwd.sv
src/id_exe_reg.sv
src/id_top.sv
dv/tb_id_top.sv

// File: src/id_exe_reg.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_exe_reg
    import id_pkg::*;
(
    input  logic               cpu_clk,
    input  logic               arst_n_i,
    input  logic               stall_i,
    input  id_ctrl_t           ctrl_i,
    input  logic [`WORD_W-1:0] src1_i,
    input  logic [`WORD_W-1:0] src2_i,
    input  logic [`WORD_W-1:0] din_i,
    output id_exe_t            id_exe_o
);

    id_exe_t nxt;

    always_comb begin
        nxt.alutype = ctrl_i.alutype;
        nxt.aluop   = ctrl_i.aluop;
        nxt.wreg    = ctrl_i.wreg;
        nxt.mreg    = ctrl_i.mreg;
        nxt.wa      = ctrl_i.wa;
        nxt.src1    = src1_i;
        nxt.src2    = src2_i;
        nxt.din     = din_i;
    end

    always_ff @(posedge cpu_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_exe_o <= '0;
        end else if (stall_i) begin
            id_exe_o <= '0;   // bubble
        end else begin
            id_exe_o <= nxt;
        end
    end

endmodule

// File: src/id_pkg.sv
`include "id_defs.svh"

package id_pkg;

    // one-hot class bits for arith, logic and shift
    typedef enum logic [`ALUTYPE_W-1:0] {
        NOP   = 3'b000,
        ARITH = 3'b001,
        LOGIC = 3'b010,
        SHIFT = 3'b100
    } alutype_t;

    typedef enum logic [`ALUOP_W-1:0] {
        ALU_NOP   = 8'h00,
        ALU_LUI   = 8'h05,
        ALU_SLL   = 8'h11,
        ALU_SLLV  = 8'h12,
        ALU_SUB   = 8'h16,
        ALU_ADDU  = 8'h17,
        ALU_ADD   = 8'h18,
        ALU_ADDIU = 8'h19,
        ALU_ADDI  = 8'h1A,
        ALU_SUBU  = 8'h1B,
        ALU_AND   = 8'h1C,
        ALU_ORI   = 8'h1D,
        ALU_ANDI  = 8'h1E,
        ALU_NOR   = 8'h1F,
        ALU_OR    = 8'h20,
        ALU_XOR   = 8'h21,
        ALU_XORI  = 8'h22,
        ALU_SLT   = 8'h26,
        ALU_SLTIU = 8'h27,
        ALU_SLTI  = 8'h28,
        ALU_SLTU  = 8'h29,
        ALU_SRA   = 8'h2A,
        ALU_SRAV  = 8'h2B,
        ALU_SRL   = 8'h2C,
        ALU_SRLV  = 8'h2D,
        ALU_LB    = 8'h90,   // memory ops have bit 7 set
        ALU_LBU   = 8'h91,
        ALU_LW    = 8'h92,
        ALU_LH    = 8'h94,
        ALU_LHU   = 8'h96,
        ALU_SB    = 8'h98,
        ALU_SH    = 8'h99,
        ALU_SW    = 8'h9A
    } aluop_t;

    // pending write of a later stage
    typedef struct packed {
        logic                   wreg;
        logic                   mreg;
        logic [`REG_ADDR_W-1:0] wa;
        logic [`WORD_W-1:0]     wd;
    } fwd_src_t;

    typedef struct packed {
        logic                   rreg1;
        logic [`REG_ADDR_W-1:0] ra1;
        logic                   rreg2;
        logic [`REG_ADDR_W-1:0] ra2;
    } rf_rd_t;

    typedef struct packed {
        alutype_t               alutype;
        aluop_t                 aluop;
        logic                   wreg;
        logic                   mreg;
        logic [`REG_ADDR_W-1:0] wa;
        rf_rd_t                 rd_req;
        logic                   shift;
        logic                   immsel;
        logic [`SA_W-1:0]       sa;
        logic [`WORD_W-1:0]     imm_ext;
    } id_ctrl_t;

    typedef struct packed {
        alutype_t               alutype;
        aluop_t                 aluop;
        logic                   wreg;
        logic                   mreg;
        logic [`REG_ADDR_W-1:0] wa;
        logic [`WORD_W-1:0]     src1;
        logic [`WORD_W-1:0]     src2;
        logic [`WORD_W-1:0]     din;
    } id_exe_t;

endpackage

// File: src/id_top.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module id_top
    import id_pkg::*;
(
    input  logic               cpu_clk,
    input  logic               arst_n_i,
    input  logic [`WORD_W-1:0] inst_i,
    input  logic [`WORD_W-1:0] rd1_i,
    input  logic [`WORD_W-1:0] rd2_i,
    input  fwd_src_t           exe_fwd_i,
    input  fwd_src_t           mem_fwd_i,
    output rf_rd_t             rf_rd_o,
    output logic               stall_o,
    output id_exe_t            id_exe_o
);

    id_ctrl_t           ctrl;
    logic [`WORD_W-1:0] src1;
    logic [`WORD_W-1:0] src2;
    logic [`WORD_W-1:0] din;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    operand_fwd u_fwd (
        .ctrl_i    (ctrl),
        .rd1_i     (rd1_i),
        .rd2_i     (rd2_i),
        .exe_fwd_i (exe_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .rf_rd_o   (rf_rd_o),
        .src1_o    (src1),
        .src2_o    (src2),
        .din_o     (din),
        .stall_o   (stall_o)
    );

    id_exe_reg u_id_exe (
        .cpu_clk  (cpu_clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_o),
        .ctrl_i   (ctrl),
        .src1_i   (src1),
        .src2_i   (src2),
        .din_i    (din),
        .id_exe_o (id_exe_o)
    );

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module inst_decoder
    import id_pkg::*;
(
    input  logic [`WORD_W-1:0] inst_i,
    output id_ctrl_t           ctrl_o
);

    logic [`WORD_W-1:0]     inst;
    logic [`OP_W-1:0]       op;
    logic [`FUNC_W-1:0]     func;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`SA_W-1:0]       sa;
    logic [`IMM_W-1:0]      imm;

    aluop_t   aluop;
    alutype_t alutype;

    logic valid;
    logic is_load;
    logic is_store;
    logic is_imm_alu;
    logic is_logic;
    logic is_shift;
    logic is_lui;
    logic shift;
    logic rtsel;
    logic sext;

    // memory returns the word little-endian
    assign inst = {inst_i[7:0], inst_i[15:8], inst_i[23:16], inst_i[31:24]};

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];
    assign imm  = inst[15:0];

    always_comb begin
        aluop = ALU_NOP;
        case (op)
            `OP_SPECIAL: begin
                case (func)
                    `FUNC_ADD:  aluop = ALU_ADD;
                    `FUNC_ADDU: aluop = ALU_ADDU;
                    `FUNC_SUB:  aluop = ALU_SUB;
                    `FUNC_SUBU: aluop = ALU_SUBU;
                    `FUNC_SLT:  aluop = ALU_SLT;
                    `FUNC_SLTU: aluop = ALU_SLTU;
                    `FUNC_AND:  aluop = ALU_AND;
                    `FUNC_OR:   aluop = ALU_OR;
                    `FUNC_NOR:  aluop = ALU_NOR;
                    `FUNC_XOR:  aluop = ALU_XOR;
                    `FUNC_SLL:  aluop = ALU_SLL;
                    `FUNC_SRL:  aluop = ALU_SRL;
                    `FUNC_SRA:  aluop = ALU_SRA;
                    `FUNC_SLLV: aluop = ALU_SLLV;
                    `FUNC_SRLV: aluop = ALU_SRLV;
                    `FUNC_SRAV: aluop = ALU_SRAV;
                    default:    aluop = ALU_NOP;
                endcase
            end
            `OP_ADDI:  aluop = ALU_ADDI;
            `OP_ADDIU: aluop = ALU_ADDIU;
            `OP_SLTI:  aluop = ALU_SLTI;
            `OP_SLTIU: aluop = ALU_SLTIU;
            `OP_ANDI:  aluop = ALU_ANDI;
            `OP_ORI:   aluop = ALU_ORI;
            `OP_XORI:  aluop = ALU_XORI;
            `OP_LUI:   aluop = ALU_LUI;
            `OP_LB:    aluop = ALU_LB;
            `OP_LBU:   aluop = ALU_LBU;
            `OP_LH:    aluop = ALU_LH;
            `OP_LHU:   aluop = ALU_LHU;
            `OP_LW:    aluop = ALU_LW;
            `OP_SB:    aluop = ALU_SB;
            `OP_SH:    aluop = ALU_SH;
            `OP_SW:    aluop = ALU_SW;
            default:   aluop = ALU_NOP;   // anything else is a no-op
        endcase
    end

    // instruction classes
    assign valid      = (aluop != ALU_NOP);
    assign is_load    = aluop inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};
    assign is_store   = aluop inside {ALU_SB, ALU_SH, ALU_SW};
    assign is_lui     = (aluop == ALU_LUI);
    assign is_imm_alu = aluop inside {ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU,
                                      ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LUI};
    assign is_logic   = aluop inside {ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
                                      ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LUI};
    assign is_shift   = aluop inside {ALU_SLL, ALU_SRL, ALU_SRA,
                                      ALU_SLLV, ALU_SRLV, ALU_SRAV};
    assign shift      = aluop inside {ALU_SLL, ALU_SRL, ALU_SRA};   // amount from sa
    assign rtsel      = is_imm_alu | is_load;
    assign sext       = is_load | is_store |
                        (aluop inside {ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU});

    always_comb begin
        if (is_shift) begin
            alutype = SHIFT;
        end else if (is_logic) begin
            alutype = LOGIC;
        end else if (valid) begin
            alutype = ARITH;   // includes address calc
        end else begin
            alutype = NOP;
        end
    end

    always_comb begin
        ctrl_o.alutype      = alutype;
        ctrl_o.aluop        = aluop;
        ctrl_o.wreg         = valid & ~is_store;
        ctrl_o.mreg         = is_load;
        ctrl_o.wa           = rtsel ? rt : rd;
        ctrl_o.rd_req.rreg1 = valid & ~shift & ~is_lui;
        ctrl_o.rd_req.ra1   = rs;
        ctrl_o.rd_req.rreg2 = valid & ~rtsel;   // R-type and stores
        ctrl_o.rd_req.ra2   = rt;
        ctrl_o.shift        = shift;
        ctrl_o.immsel       = rtsel | is_store;
        ctrl_o.sa           = sa;
        if (is_lui) begin
            ctrl_o.imm_ext = {imm, {(`WORD_W-`IMM_W){1'b0}}};
        end else if (sext) begin
            ctrl_o.imm_ext = {{(`WORD_W-`IMM_W){imm[`IMM_W-1]}}, imm};
        end else begin
            ctrl_o.imm_ext = {{(`WORD_W-`IMM_W){1'b0}}, imm};
        end
    end

endmodule

// File: src/operand_fwd.sv
`timescale 1ns/1ps
`include "id_defs.svh"

module operand_fwd
    import id_pkg::*;
(
    input  id_ctrl_t           ctrl_i,
    input  logic [`WORD_W-1:0] rd1_i,
    input  logic [`WORD_W-1:0] rd2_i,
    input  fwd_src_t           exe_fwd_i,
    input  fwd_src_t           mem_fwd_i,
    output rf_rd_t             rf_rd_o,
    output logic [`WORD_W-1:0] src1_o,
    output logic [`WORD_W-1:0] src2_o,
    output logic [`WORD_W-1:0] din_o,
    output logic               stall_o
);

    logic [`WORD_W-1:0] fwd1;
    logic [`WORD_W-1:0] fwd2;

    // execute first, then memory, then register file
    function automatic logic [`WORD_W-1:0] fwd_data(
        input logic                   en,
        input logic [`REG_ADDR_W-1:0] ra,
        input fwd_src_t               exe,
        input fwd_src_t               mem,
        input logic [`WORD_W-1:0]     rf
    );
        logic [`WORD_W-1:0] d;
        d = '0;
        if (en && exe.wreg && exe.wa == ra) begin
            d = exe.wd;
        end else if (en && mem.wreg && mem.wa == ra) begin
            d = mem.wd;
        end else if (en) begin
            d = rf;
        end
        return d;
    endfunction

    // pending load result wanted by either port
    function automatic logic load_hit(input fwd_src_t src, input rf_rd_t rq);
        logic hit1;
        logic hit2;
        hit1 = rq.rreg1 && (src.wa == rq.ra1);
        hit2 = rq.rreg2 && (src.wa == rq.ra2);
        return src.wreg && src.mreg && (hit1 || hit2);
    endfunction

    assign rf_rd_o = ctrl_i.rd_req;

    assign fwd1 = fwd_data(ctrl_i.rd_req.rreg1, ctrl_i.rd_req.ra1, exe_fwd_i, mem_fwd_i, rd1_i);
    assign fwd2 = fwd_data(ctrl_i.rd_req.rreg2, ctrl_i.rd_req.ra2, exe_fwd_i, mem_fwd_i, rd2_i);

    assign src1_o = ctrl_i.shift ? {{(`WORD_W-`SA_W){1'b0}}, ctrl_i.sa} : fwd1;
    assign src2_o = ctrl_i.immsel ? ctrl_i.imm_ext : fwd2;
    assign din_o  = fwd2;   // store data

    assign stall_o = load_hit(exe_fwd_i, ctrl_i.rd_req) | load_hit(mem_fwd_i, ctrl_i.rd_req);

endmodule
